// ==== src/vdu_pkg.sv ====
`default_nettype none

package vdu_pkg;

  // Horizontal timing, in pixel clocks
  localparam logic [9:0] HOR_DISP_END = 10'd639;
  localparam logic [9:0] HOR_SYNC_BEG = 10'd679;
  localparam logic [9:0] HOR_SYNC_END = 10'd775; // 96 clock sync pulse
  localparam logic [9:0] HOR_SCAN_END = 10'd799;

  // Vertical timing, in scan lines
  localparam logic [8:0] VER_DISP_END = 9'd399;
  localparam logic [8:0] VER_SYNC_BEG = 9'd413;
  localparam logic [8:0] VER_SYNC_END = 9'd414;
  localparam logic [8:0] VER_SCAN_END = 9'd450;

  // Screen geometry
  localparam logic [6:0]  TEXT_COLS  = 7'd80;
  localparam logic [5:0]  TEXT_ROWS  = 6'd25;
  localparam logic [11:0] TEXT_CELLS = 12'd2000;
  localparam int          PIX_LAT    = 3; // Counter to pixel latency

  // Word address map
  localparam logic [11:0] TEXT_BASE   = 12'h000;
  localparam logic [11:0] REG_HCURSOR = 12'h7F0;
  localparam logic [11:0] REG_VCURSOR = 12'h7F1;
  localparam logic [11:0] REG_VOFFSET = 12'h7F2;
  localparam logic [11:0] FONT_BASE   = 12'h800; // Even glyph row in low byte

  typedef logic [7:0] char_t;

  // Attribute byte, msb first
  typedef struct packed {
    logic       graphic; // 2x4 block cell
    logic [2:0] bg;
    logic       cursor;
    logic [2:0] fg;
  } attr_t;

  typedef logic [2:0] rgb_t; // Red in bit 0

endpackage

`default_nettype wire

// ==== src/vdu_timing.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_timing
  (
    input  logic       vdu_clk_in,
    input  logic       vdu_rst,
    output logic [9:0] h_count_o,
    output logic [8:0] v_count_o,
    output logic       video_on_o,
    output logic       horiz_sync_o,
    output logic       vert_sync_o,
    output logic       host_slot_o
  );

  import vdu_pkg::*;

  logic line_end;

  assign line_end = (h_count_o == HOR_SCAN_END);

  always_ff @(posedge vdu_clk_in)
  begin
    if (vdu_rst)
    begin
      h_count_o    <= '0;
      v_count_o    <= '0;
      horiz_sync_o <= 1'b1;
      vert_sync_o  <= 1'b1;
    end
    else
    begin
      h_count_o <= line_end ? 10'd0 : h_count_o + 10'd1;

      // Line counter steps at the end of each scan line
      if (line_end)
        v_count_o <= (v_count_o == VER_SCAN_END) ? 9'd0 : v_count_o + 9'd1;

      if (h_count_o == HOR_SYNC_BEG)
        horiz_sync_o <= 1'b0;
      else if (h_count_o == HOR_SYNC_END)
        horiz_sync_o <= 1'b1;

      // Low for the whole of line VER_SYNC_BEG
      if (v_count_o == VER_SYNC_BEG)
        vert_sync_o <= 1'b0;
      else if (v_count_o == VER_SYNC_END)
        vert_sync_o <= 1'b1;
    end
  end

  assign video_on_o  = (h_count_o <= HOR_DISP_END) && (v_count_o <= VER_DISP_END);
  assign host_slot_o = (h_count_o[2:0] == 3'd0); // First pixel of every cell

endmodule

`default_nettype wire

// ==== src/vdu_text_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_text_ram
  #(
    parameter type payload_t = logic [7:0]
  )
  (
    input  logic      vdu_clk_in,
    input  logic      we_i,
    input  logic [10:0] addr_i,
    input  payload_t  wdata_i,
    output payload_t  rdata_o
  );

  // One entry per word address, 2000 of them are screen cells
  payload_t mem [2048];

  always_ff @(posedge vdu_clk_in)
  begin
    if (we_i)
      mem[addr_i] <= wdata_i;
  end

  // Registered read, old data on a write cycle
  always_ff @(posedge vdu_clk_in)
  begin
    rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// ==== src/vdu_font_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_font_ram
  (
    input  logic        vdu_clk_in,
    input  logic        we_i,
    input  logic [11:0] addr_i,
    input  logic [7:0]  wdata_i,
    output logic [7:0]  rdata_o
  );

  // Address is {character code, glyph row}
  logic [7:0] glyph_mem [4096];

  always_ff @(posedge vdu_clk_in)
  begin
    if (we_i)
      glyph_mem[addr_i] <= wdata_i; // Loaded by the host
  end

  always_ff @(posedge vdu_clk_in)
  begin
    rdata_o <= glyph_mem[addr_i];
  end

endmodule

`default_nettype wire

// ==== src/vdu_bus_port.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_bus_port
  (
    input  logic               vdu_clk_in,
    input  logic               vdu_rst,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [11:0]        wb_adr_i,
    input  logic [1:0]         wb_sel_i,
    input  logic [15:0]        wb_dat_i,
    output logic [15:0]        wb_dat_o,
    output logic               wb_ack_o,
    input  logic               host_slot_i,
    input  logic [10:0]        disp_text_addr_i,
    input  logic [11:0]        disp_font_addr_i,
    output logic [10:0]        text_addr_o,
    output logic               char_we_o,
    output logic               attr_we_o,
    output vdu_pkg::char_t     char_wdata_o,
    output vdu_pkg::attr_t     attr_wdata_o,
    input  vdu_pkg::char_t     char_rdata_i,
    input  vdu_pkg::attr_t     attr_rdata_i,
    output logic [11:0]        font_addr_o,
    output logic               font_we_o,
    output logic [7:0]         font_wdata_o,
    input  logic [7:0]         font_rdata_i,
    output logic [6:0]         hcursor_o,
    output logic [4:0]         vcursor_o,
    output logic [4:0]         voffset_o
  );

  import vdu_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_REG, ST_SLOT, ST_ACK, ST_GAP} bus_state_t;

  bus_state_t  state;
  logic        is_font;
  logic        is_text;
  logic        font_lane;
  logic        ram_cycle;
  logic [10:0] host_text_addr;
  logic [11:0] host_font_addr;

  assign is_font   = (wb_adr_i >= FONT_BASE);
  assign is_text   = (wb_adr_i < TEXT_CELLS);
  assign font_lane = ~wb_sel_i[0]; // Font port is one byte wide, lane 0 wins

  assign host_text_addr = wb_adr_i[10:0] - TEXT_BASE[10:0];
  assign host_font_addr = {wb_adr_i[10:0] - FONT_BASE[10:0], font_lane};

  always_ff @(posedge vdu_clk_in)
  begin
    if (vdu_rst)
    begin
      state     <= ST_IDLE;
      hcursor_o <= '0;
      vcursor_o <= '0;
      voffset_o <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (wb_cyc_i && wb_stb_i)
            state <= (is_font || is_text) ? ST_SLOT : ST_REG;
        ST_REG:
        begin
          state <= ST_ACK;
          if (wb_we_i && wb_sel_i[0])
          begin
            case (wb_adr_i)
              REG_HCURSOR: hcursor_o <= wb_dat_i[6:0];
              REG_VCURSOR: vcursor_o <= wb_dat_i[4:0];
              REG_VOFFSET: voffset_o <= wb_dat_i[4:0];
              default: ;
            endcase
          end
        end
        ST_SLOT:
          if (host_slot_i)
            state <= ST_ACK;
        ST_ACK:  state <= ST_GAP;  // stb not sampled next cycle
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign wb_ack_o  = (state == ST_ACK);
  assign ram_cycle = (state == ST_SLOT) && host_slot_i;

  // Host owns both RAM ports only in the slot cycle
  assign text_addr_o = host_slot_i ? host_text_addr : disp_text_addr_i;
  assign font_addr_o = host_slot_i ? host_font_addr : disp_font_addr_i;

  assign char_we_o    = ram_cycle && wb_we_i && is_text && wb_sel_i[0];
  assign attr_we_o    = ram_cycle && wb_we_i && is_text && wb_sel_i[1];
  assign font_we_o    = ram_cycle && wb_we_i && is_font && (wb_sel_i != 2'b00);
  assign char_wdata_o = wb_dat_i[7:0];
  assign attr_wdata_o = attr_t'(wb_dat_i[15:8]);
  assign font_wdata_o = font_lane ? wb_dat_i[15:8] : wb_dat_i[7:0];

  // RAM data is valid in the ack cycle, one after the slot
  always_comb
  begin
    if (is_font)
      wb_dat_o = font_lane ? {font_rdata_i, 8'h00} : {8'h00, font_rdata_i};
    else if (is_text)
      wb_dat_o = {attr_rdata_i, char_rdata_i};
    else
    begin
      case (wb_adr_i)
        REG_HCURSOR: wb_dat_o = {9'd0, hcursor_o};
        REG_VCURSOR: wb_dat_o = {11'd0, vcursor_o};
        REG_VOFFSET: wb_dat_o = {11'd0, voffset_o};
        default:     wb_dat_o = 16'h0000; // Unmapped words read zero
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/vdu_pixel_pipe.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_pixel_pipe
  (
    input  logic           vdu_clk_in,
    input  logic           vdu_rst,
    input  logic [9:0]     h_count_i,
    input  logic [8:0]     v_count_i,
    input  logic           video_on_i,
    input  logic [6:0]     hcursor_i,
    input  logic [4:0]     vcursor_i,
    input  logic [4:0]     voffset_i,
    output logic [10:0]    text_addr_o,
    output logic [11:0]    font_addr_o,
    input  vdu_pkg::char_t char_i,
    input  vdu_pkg::attr_t attr_i,
    input  logic [7:0]     glyph_i,
    output logic           red_o,
    output logic           green_o,
    output logic           blue_o
  );

  import vdu_pkg::*;

  logic              last_col;
  logic [8:0]        v_next;
  logic [8:0]        fetch_v;
  logic [5:0]        voff_mod;
  logic [5:0]        row_sum;
  logic [5:0]        row_mod;
  logic [6:0]        col_s1, col_s2;
  logic [3:0]        line_s1, line_s2, line_s3;
  logic [7:0]        blocks;
  logic [7:0]        next_pat;
  attr_t             next_attr;
  logic [7:0]        shift;
  rgb_t              fg_col, bg_col;
  logic              cursor_on;
  logic              cur_d1;
  logic              load_d1;
  logic [PIX_LAT-2:0] von_d;
  rgb_t              pix_col;

  // Each cell fetches the next one, the last one fetches column 0 of the next line
  assign last_col = (h_count_i[9:3] == HOR_SCAN_END[9:3]);
  assign v_next   = (v_count_i == VER_SCAN_END) ? 9'd0 : v_count_i + 9'd1;
  assign fetch_v  = last_col ? v_next : v_count_i;
  assign voff_mod = ({1'b0, voffset_i} >= TEXT_ROWS) ? {1'b0, voffset_i} - TEXT_ROWS
                                                     : {1'b0, voffset_i};

  always_ff @(posedge vdu_clk_in)
  begin
    row_sum <= {1'b0, fetch_v[8:4]} + voff_mod;
    col_s1  <= last_col ? 7'd0 : h_count_i[9:3] + 7'd1;
    line_s1 <= fetch_v[3:0];
    row_mod <= (row_sum >= TEXT_ROWS) ? row_sum - TEXT_ROWS : row_sum; // Mod 25
    col_s2  <= col_s1;
    line_s2 <= line_s1;
    text_addr_o <= 11'(row_mod) * 11'(TEXT_COLS) + 11'(col_s2);
    line_s3 <= line_s2;
  end

  assign font_addr_o = {char_i, line_s3};

  // 2x4 blocks, the scan line quarter picks a bit pair
  assign blocks = {{4{char_i[{line_s3[3:2], 1'b0}]}}, {4{char_i[{line_s3[3:2], 1'b1}]}}};

  always_ff @(posedge vdu_clk_in)
  begin
    if (h_count_i[2:0] == 3'd7) // Text and glyph data settled by now
    begin
      next_pat  <= attr_i.graphic ? blocks : glyph_i;
      next_attr <= attr_i;
    end
    if (load_d1)
    begin
      shift  <= next_pat;
      fg_col <= next_attr.fg;
      bg_col <= next_attr.bg;
    end
    else
      shift <= {shift[6:0], 1'b0};
  end

  assign pix_col = (shift[7] ^ cursor_on) ? fg_col : bg_col;

  always_ff @(posedge vdu_clk_in)
  begin
    if (vdu_rst)
    begin
      load_d1   <= 1'b0;
      cur_d1    <= 1'b0;
      cursor_on <= 1'b0;
      von_d     <= '0;
      red_o     <= 1'b0;
      green_o   <= 1'b0;
      blue_o    <= 1'b0;
    end
    else
    begin
      load_d1 <= (h_count_i[2:0] == 3'd0);
      cur_d1  <= (h_count_i[9:3] == hcursor_i) && (v_count_i[8:4] == vcursor_i);
      if (load_d1)
        cursor_on <= cur_d1 | next_attr.cursor; // Solid, no blink
      von_d   <= {von_d[PIX_LAT-3:0], video_on_i};
      red_o   <= von_d[PIX_LAT-2] & pix_col[0];
      green_o <= von_d[PIX_LAT-2] & pix_col[1];
      blue_o  <= von_d[PIX_LAT-2] & pix_col[2];
    end
  end

endmodule

`default_nettype wire

// ==== src/vdu.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu
  (
    input  logic        vdu_clk_in,
    input  logic        vdu_rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [11:0] wb_adr_i,
    input  logic [1:0]  wb_sel_i,
    input  logic [15:0] wb_dat_i,
    output logic [15:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        vga_red_o,
    output logic        vga_green_o,
    output logic        vga_blue_o,
    output logic        horiz_sync_o,
    output logic        vert_sync_o
  );

  import vdu_pkg::*;

  logic [9:0]  h_count;
  logic [8:0]  v_count;
  logic        video_on;
  logic        host_slot;
  logic [10:0] disp_text_addr;
  logic [11:0] disp_font_addr;
  logic [10:0] text_addr;
  logic        char_we, attr_we;
  char_t       char_wdata, char_rdata;
  attr_t       attr_wdata, attr_rdata;
  logic [11:0] font_addr;
  logic        font_we;
  logic [7:0]  font_wdata, font_rdata;
  logic [6:0]  hcursor;
  logic [4:0]  vcursor;
  logic [4:0]  voffset;

  vdu_timing timing_inst (
    .vdu_clk_in   (vdu_clk_in),
    .vdu_rst      (vdu_rst),
    .h_count_o    (h_count),
    .v_count_o    (v_count),
    .video_on_o   (video_on),
    .horiz_sync_o (horiz_sync_o),
    .vert_sync_o  (vert_sync_o),
    .host_slot_o  (host_slot)
  );

  vdu_bus_port bus_inst (
    .vdu_clk_in       (vdu_clk_in),
    .vdu_rst          (vdu_rst),
    .wb_cyc_i         (wb_cyc_i),
    .wb_stb_i         (wb_stb_i),
    .wb_we_i          (wb_we_i),
    .wb_adr_i         (wb_adr_i),
    .wb_sel_i         (wb_sel_i),
    .wb_dat_i         (wb_dat_i),
    .wb_dat_o         (wb_dat_o),
    .wb_ack_o         (wb_ack_o),
    .host_slot_i      (host_slot),
    .disp_text_addr_i (disp_text_addr),
    .disp_font_addr_i (disp_font_addr),
    .text_addr_o      (text_addr),
    .char_we_o        (char_we),
    .attr_we_o        (attr_we),
    .char_wdata_o     (char_wdata),
    .attr_wdata_o     (attr_wdata),
    .char_rdata_i     (char_rdata),
    .attr_rdata_i     (attr_rdata),
    .font_addr_o      (font_addr),
    .font_we_o        (font_we),
    .font_wdata_o     (font_wdata),
    .font_rdata_i     (font_rdata),
    .hcursor_o        (hcursor),
    .vcursor_o        (vcursor),
    .voffset_o        (voffset)
  );

  vdu_pixel_pipe pipe_inst (
    .vdu_clk_in  (vdu_clk_in),
    .vdu_rst     (vdu_rst),
    .h_count_i   (h_count),
    .v_count_i   (v_count),
    .video_on_i  (video_on),
    .hcursor_i   (hcursor),
    .vcursor_i   (vcursor),
    .voffset_i   (voffset),
    .text_addr_o (disp_text_addr),
    .font_addr_o (disp_font_addr),
    .char_i      (char_rdata),
    .attr_i      (attr_rdata),
    .glyph_i     (font_rdata),
    .red_o       (vga_red_o),
    .green_o     (vga_green_o),
    .blue_o      (vga_blue_o)
  );

  // Character and attribute planes share one address
  vdu_text_ram #(.payload_t(char_t)) char_ram_inst (
    .vdu_clk_in (vdu_clk_in),
    .we_i       (char_we),
    .addr_i     (text_addr),
    .wdata_i    (char_wdata),
    .rdata_o    (char_rdata)
  );

  vdu_text_ram #(.payload_t(attr_t)) attr_ram_inst (
    .vdu_clk_in (vdu_clk_in),
    .we_i       (attr_we),
    .addr_i     (text_addr),
    .wdata_i    (attr_wdata),
    .rdata_o    (attr_rdata)
  );

  vdu_font_ram font_ram_inst (
    .vdu_clk_in (vdu_clk_in),
    .we_i       (font_we),
    .addr_i     (font_addr),
    .wdata_i    (font_wdata),
    .rdata_o    (font_rdata)
  );

endmodule

`default_nettype wire

// ==== bench/vdu_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module vdu_tb;

  localparam int          CLK_HALF     = 2;
  localparam int          DRIVE_DLY    = 1;
  localparam logic [31:0] SEED         = 32'h5e31;
  localparam int          LINE_CYCLES  = 800;
  localparam int          FRAME_CYCLES = 451 * 800;
  localparam int          WD_FRAMES    = 20;

  logic        vdu_clk_in;
  logic        vdu_rst;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [11:0] wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        vga_red_o;
  logic        vga_green_o;
  logic        vga_blue_o;
  logic        horiz_sync_o;
  logic        vert_sync_o;

  int          errors;
  int          checks;
  int          wd_cycles;
  bit          cmds_loaded;
  logic [31:0] rng_state;
  logic [15:0] text_model [2048]; // Expected text words
  logic [7:0]  cmd_q [$];
  logic [31:0] fa_q [$];
  logic [31:0] fb_q [$];
  logic [31:0] fc_q [$];
  logic [31:0] fd_q [$];

  vdu vdu_inst (
    .vdu_clk_in   (vdu_clk_in),
    .vdu_rst      (vdu_rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .vga_red_o    (vga_red_o),
    .vga_green_o  (vga_green_o),
    .vga_blue_o   (vga_blue_o),
    .horiz_sync_o (horiz_sync_o),
    .vert_sync_o  (vert_sync_o)
  );

  always #CLK_HALF vdu_clk_in = ~vdu_clk_in;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
  endtask

  // One Wishbone classic cycle, data sampled mid-cycle when ack is high
  task automatic bus_access(input logic we, input logic [11:0] adr, input logic [1:0] sel,
                            input logic [15:0] dat, output logic [15:0] rdat);
    int cycles;
    bit is_reg;
    begin
      is_reg = (adr >= 12'd2000) && (adr < 12'h800);
      @(posedge vdu_clk_in);
      #DRIVE_DLY;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_sel_i = sel;
      wb_dat_i = dat;
      cycles   = 0;
      @(negedge vdu_clk_in); // Cycle in which stb is first driven
      while (!wb_ack_o && cycles < 20)
      begin
        @(negedge vdu_clk_in);
        cycles++;
      end
      rdat = wb_dat_o;
      checks++;
      if (!wb_ack_o)
      begin
        errors++;
        $display("No ack from the DUT for address %h", adr);
      end
      else if (is_reg && cycles != 2)
        report_mismatch("wb_ack_o latency", cycles, 2);
      else if (!is_reg && (cycles < 2 || cycles > 9))
      begin
        errors++;
        $display("RAM access at %h took %0d cycles, outside 2 to 9", adr, cycles);
      end
      @(posedge vdu_clk_in);
      #DRIVE_DLY;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
    end
  endtask

  task automatic write_word(input logic [11:0] adr, input logic [1:0] sel,
                            input logic [15:0] dat);
    logic [15:0] unused;
    begin
      bus_access(1'b1, adr, sel, dat, unused);
      if (adr < 12'd2000)
      begin
        if (sel[0])
          text_model[adr[10:0]][7:0] = dat[7:0];
        if (sel[1])
          text_model[adr[10:0]][15:8] = dat[15:8];
      end
    end
  endtask

  task automatic read_check(input logic [11:0] adr, input logic [1:0] sel,
                            input logic [15:0] exp);
    logic [15:0] rdat;
    begin
      bus_access(1'b0, adr, sel, 16'h0000, rdat);
      checks++;
      if (rdat !== exp)
        report_mismatch("wb_dat_o", rdat, exp);
    end
  endtask

  // Full write, then a random lane write, then compare with the model
  task automatic random_fill(input logic [11:0] base, input int count);
    logic [11:0] a;
    logic [1:0]  sel;
    begin
      for (int i = 0; i < count; i++)
      begin
        a = base + 12'(i);
        rng_state = lcg_next(rng_state);
        write_word(a, 2'b11, rng_state[31:16]);
        rng_state = lcg_next(rng_state);
        sel = (rng_state[17:16] == 2'b00) ? 2'b01 : rng_state[17:16];
        write_word(a, sel, rng_state[31:16]);
        read_check(a, 2'b11, text_model[a[10:0]]);
      end
    end
  endtask

  task automatic wait_hsync_fall;
    @(negedge vdu_clk_in);
    while (horiz_sync_o !== 1'b1)
      @(negedge vdu_clk_in);
    while (horiz_sync_o !== 1'b0)
      @(negedge vdu_clk_in);
  endtask

  task automatic wait_vsync_fall;
    @(negedge vdu_clk_in);
    while (vert_sync_o !== 1'b1)
      @(negedge vdu_clk_in);
    while (vert_sync_o !== 1'b0)
      @(negedge vdu_clk_in);
  endtask

  // Vsync falls on line 413, hsync at counter 680, pixel h shows 123 + h later
  task automatic check_line(input int scan_line, input int col, input logic [2:0] fg,
                            input int exp);
    int hits;
    logic [2:0] rgb;
    begin
      hits = 0;
      wait_vsync_fall();
      repeat (38 + scan_line) wait_hsync_fall();
      repeat (123 + 8 * col) @(negedge vdu_clk_in);
      for (int k = 0; k < 8; k++)
      begin
        if (k > 0)
          @(negedge vdu_clk_in);
        rgb = {vga_blue_o, vga_green_o, vga_red_o};
        if (rgb == fg)
          hits++;
      end
      checks++;
      if (hits != exp)
        report_mismatch("foreground pixel count", hits, exp);
    end
  endtask

  task automatic check_frame;
    int       fall_cnt;
    int       line_no;
    int       oh;
    int       ol;
    bit       seen_fall;
    bit       vs_fall_seen;
    logic     hs_prev;
    logic     vs_prev;
    logic [2:0] rgb;
    begin
      // White block cell at row 1 column 0, fetched again in both blanking intervals
      write_word(12'd80, 2'b11, 16'hF000);
      wait_vsync_fall();
      hs_prev      = horiz_sync_o;
      vs_prev      = 1'b0;
      seen_fall    = 1'b0;
      vs_fall_seen = 1'b0;
      fall_cnt     = 0;
      line_no      = 0;
      for (int cnt = 0; cnt < FRAME_CYCLES + 100; cnt++)
      begin
        if (cnt > 0)
          @(negedge vdu_clk_in);
        if (hs_prev && !horiz_sync_o)
        begin
          if (seen_fall && cnt - fall_cnt != LINE_CYCLES)
            report_mismatch("horiz_sync_o period", cnt - fall_cnt, LINE_CYCLES);
          line_no   = seen_fall ? (line_no + 1) % 451 : 413;
          seen_fall = 1'b1;
          fall_cnt  = cnt;
        end
        if (!hs_prev && horiz_sync_o && seen_fall && cnt - fall_cnt != 96)
          report_mismatch("horiz_sync_o low time", cnt - fall_cnt, 96);
        if (!vs_prev && vert_sync_o && cnt != LINE_CYCLES)
          report_mismatch("vert_sync_o low time", cnt, LINE_CYCLES);
        if (vs_prev && !vert_sync_o)
        begin
          vs_fall_seen = 1'b1;
          if (cnt != FRAME_CYCLES)
            report_mismatch("vert_sync_o period", cnt, FRAME_CYCLES);
        end
        if (seen_fall)
        begin
          oh = 677 + cnt - fall_cnt; // Counter position of the pixel on the pins
          ol = line_no;
          if (oh >= LINE_CYCLES)
          begin
            oh = oh - LINE_CYCLES;
            ol = (line_no + 1) % 451;
          end
          rgb = {vga_blue_o, vga_green_o, vga_red_o};
          if ((ol > 399 || oh > 639) && rgb != 3'b000)
            report_mismatch("vga rgb outside window", 32'(rgb), 0);
        end
        hs_prev = horiz_sync_o;
        vs_prev = vert_sync_o;
      end
      checks++;
      if (!vs_fall_seen)
      begin
        errors++;
        $display("No second vertical sync pulse within one frame");
      end
    end
  endtask

  task automatic load_tests;
    int          fh;
    int          n;
    string       text;
    logic [7:0]  c;
    logic [31:0] fa, fb, fc, fd;
    begin
      fh = $fopen("bench/vdu_tests.txt", "r");
      if (fh == 0)
      begin
        errors++;
        $display("Cannot open the test command file");
      end
      else
      begin
        while (!$feof(fh))
        begin
          n  = $fgets(text, fh);
          fa = 0;
          fb = 0;
          fc = 0;
          fd = 0;
          if (n > 1)
          begin
            c = text.getc(0);
            if (c == "W" || c == "R" || c == "X" || c == "L" || c == "F")
            begin
              n = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h", fa, fb, fc, fd);
              cmd_q.push_back(c);
              fa_q.push_back(fa);
              fb_q.push_back(fb);
              fc_q.push_back(fc);
              fd_q.push_back(fd);
            end
          end
        end
        $fclose(fh);
      end
    end
  endtask

  // Watchdog
  initial
  begin
    wait (cmds_loaded);
    repeat (wd_cycles) @(posedge vdu_clk_in);
    $display("Timeout after %0d cycles, the tests did not finish", wd_cycles);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    vdu_clk_in  = 1'b0;
    vdu_rst     = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_sel_i    = '0;
    wb_dat_i    = '0;
    errors      = 0;
    checks      = 0;
    rng_state   = SEED;
    cmds_loaded = 1'b0;
    load_tests();
    wd_cycles   = WD_FRAMES * FRAME_CYCLES + 20 * cmd_q.size();
    cmds_loaded = 1'b1;
    repeat (3) @(posedge vdu_clk_in);
    #DRIVE_DLY;
    vdu_rst = 1'b0;
    for (int i = 0; i < cmd_q.size(); i++)
    begin
      case (cmd_q[i])
        "W": write_word(fa_q[i][11:0], fb_q[i][1:0], fc_q[i][15:0]);
        "R": read_check(fa_q[i][11:0], fb_q[i][1:0], fc_q[i][15:0]);
        "X": random_fill(fa_q[i][11:0], int'(fb_q[i]));
        "L": check_line(int'(fa_q[i]), int'(fb_q[i]), fc_q[i][2:0], int'(fd_q[i]));
        default: check_frame();
      endcase
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vdu.f ====
src/vdu_pkg.sv
src/vdu_timing.sv
src/vdu_text_ram.sv
src/vdu_font_ram.sv
src/vdu_bus_port.sv
src/vdu_pixel_pipe.sv
src/vdu.sv
bench/vdu_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = vdu_tb
FILELIST   = vdu.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/vdu_tests.txt ====
# W addr sel data | R addr sel expected | X base count | L line col fg count | F
# All fields hex, addresses are 12-bit word addresses
F
W A0A 1 0081
W A0A 2 E500
R A0A 1 0081
R A0A 2 E500
W 003 3 1641
R 003 3 1641
W 003 1 0042
R 003 3 1642
W 003 1 0041
X 100 10
W 005 3 A504
L 5 3 6 5
L 5 5 5 4
L D 5 5 0
W 7F0 1 0003
W 7F1 1 0000
R 7F0 1 0003
L 5 3 6 3
W 7F1 1 0010
W 0A3 3 1341
W 7F2 1 001B
R 7F2 1 001B
L 5 3 3 5
